//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dcache_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "NO ERRORS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/dcache.sv
`timescale 1ns/1ps

module dcache
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [3:0]            wstrb_i,
    input  logic [31:0]           wdata_i,
    output logic                  ready_o,
    output logic                  data_ok_o,
    output logic [31:0]           rdata_o,
    output logic                  mem_rreq_o,
    output logic [ADDR_WIDTH-1:0] mem_raddr_o,
    output logic                  mem_wreq_o,
    output logic [ADDR_WIDTH-1:0] mem_waddr_o,
    output line_t                 mem_wdata_o,
    input  logic                  mem_rvalid_i,
    input  line_t                 mem_rdata_i,
    input  logic                  mem_wdone_i
);

    logic                           stall;
    logic                           rd_en;
    index_t                         rd_index;
    logic                           s2_valid;
    mem_op_e                        s2_op;
    tag_t                           s2_tag;
    index_t                         s2_index;
    logic [OFFSET_WIDTH-1:0]        s2_offset;
    line_t                          s2_wdata;
    byte_mask_t                     s2_mask;
    index_t                         wr_index;
    logic [NWAY-1:0]                tag_we;
    logic [TAG_WIDTH+1:0]           tag_wdata;
    byte_mask_t [NWAY-1:0]          data_we;
    line_t                          data_wdata;
    logic [NWAY-1:0][TAG_WIDTH+1:0] tag_rdata;
    line_t [NWAY-1:0]               data_rdata;
    logic                           resp;
    line_t                          resp_line;

    dcache_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid_i),
        .addr_i      (addr_i),
        .wstrb_i     (wstrb_i),
        .wdata_i     (wdata_i),
        .stall_i     (stall),
        .ready_o     (ready_o),
        .rd_en_o     (rd_en),
        .rd_index_o  (rd_index),
        .s2_valid_o  (s2_valid),
        .s2_op_o     (s2_op),
        .s2_tag_o    (s2_tag),
        .s2_index_o  (s2_index),
        .s2_offset_o (s2_offset),
        .s2_wdata_o  (s2_wdata),
        .s2_mask_o   (s2_mask)
    );

    dcache_arrays u_arrays (
        .clk          (clk),
        .rst          (rst),
        .rd_en_i      (rd_en),
        .rd_index_i   (rd_index),
        .wr_index_i   (wr_index),
        .tag_we_i     (tag_we),
        .tag_wdata_i  (tag_wdata),
        .data_we_i    (data_we),
        .data_wdata_i (data_wdata),
        .tag_rdata_o  (tag_rdata),
        .data_rdata_o (data_rdata)
    );

    dcache_execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .s2_valid_i   (s2_valid),
        .s2_op_i      (s2_op),
        .s2_tag_i     (s2_tag),
        .s2_index_i   (s2_index),
        .s2_wdata_i   (s2_wdata),
        .s2_mask_i    (s2_mask),
        .tag_rdata_i  (tag_rdata),
        .data_rdata_i (data_rdata),
        .mem_wdone_i  (mem_wdone_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .stall_o      (stall),
        .wr_index_o   (wr_index),
        .tag_we_o     (tag_we),
        .tag_wdata_o  (tag_wdata),
        .data_we_o    (data_we),
        .data_wdata_o (data_wdata),
        .mem_rreq_o   (mem_rreq_o),
        .mem_raddr_o  (mem_raddr_o),
        .mem_wreq_o   (mem_wreq_o),
        .mem_waddr_o  (mem_waddr_o),
        .mem_wdata_o  (mem_wdata_o),
        .resp_o       (resp),
        .resp_line_o  (resp_line)
    );

    dcache_result u_result (
        .resp_i      (resp),
        .resp_line_i (resp_line),
        .s2_offset_i (s2_offset),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o)
    );

endmodule

//--- design/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays
    import dcache_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rd_en_i,
    input  index_t                         rd_index_i,
    input  index_t                         wr_index_i,
    input  logic [NWAY-1:0]                tag_we_i,
    input  logic [TAG_WIDTH+1:0]           tag_wdata_i,
    input  byte_mask_t [NWAY-1:0]          data_we_i,
    input  line_t                          data_wdata_i,
    output logic [NWAY-1:0][TAG_WIDTH+1:0] tag_rdata_o,
    output line_t [NWAY-1:0]               data_rdata_o
);

    // tag entry layout is {dirty, valid, tag}
    logic same_index;

    assign same_index = (rd_index_i == wr_index_i);

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        logic [TAG_WIDTH:0]   tag_mem [NSET];
        line_t                data_mem [NSET];
        logic [NSET-1:0]      valid_q;
        logic [TAG_WIDTH+1:0] tag_q;
        line_t                data_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q <= '0;
            end else if (tag_we_i[w]) begin
                valid_q[wr_index_i] <= tag_wdata_i[TAG_WIDTH];
            end
        end

        // dirty bit and tag share one RAM word
        always_ff @(posedge clk) begin
            if (tag_we_i[w]) begin
                tag_mem[wr_index_i] <= {tag_wdata_i[TAG_WIDTH+1], tag_wdata_i[TAG_WIDTH-1:0]};
            end
        end

        always_ff @(posedge clk) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (data_we_i[w][b]) begin
                    data_mem[wr_index_i][b*8 +: 8] <= data_wdata_i[b*8 +: 8];
                end
            end
        end

        // a write to the set being read in the same cycle is forwarded
        always_ff @(posedge clk) begin
            if (rd_en_i) begin
                if (tag_we_i[w] && same_index) begin
                    tag_q <= tag_wdata_i;
                end else begin
                    tag_q <= {tag_mem[rd_index_i][TAG_WIDTH], valid_q[rd_index_i],
                              tag_mem[rd_index_i][TAG_WIDTH-1:0]};
                end
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (data_we_i[w][b] && same_index) begin
                        data_q[b*8 +: 8] <= data_wdata_i[b*8 +: 8];
                    end else begin
                        data_q[b*8 +: 8] <= data_mem[rd_index_i][b*8 +: 8];
                    end
                end
            end
        end

        assign tag_rdata_o[w]  = tag_q;
        assign data_rdata_o[w] = data_q;
    end

endmodule

//--- design/dcache_decode.sv
`timescale 1ns/1ps

module dcache_decode
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_i,
    input  logic [ADDR_WIDTH-1:0]   addr_i,
    input  logic [3:0]              wstrb_i,
    input  logic [31:0]             wdata_i,
    input  logic                    stall_i,
    output logic                    ready_o,
    output logic                    rd_en_o,
    output index_t                  rd_index_o,
    output logic                    s2_valid_o,
    output mem_op_e                 s2_op_o,
    output tag_t                    s2_tag_o,
    output index_t                  s2_index_o,
    output logic [OFFSET_WIDTH-1:0] s2_offset_o,
    output line_t                   s2_wdata_o,
    output byte_mask_t              s2_mask_o
);

    logic                  s1_valid;
    logic [ADDR_WIDTH-1:0] s1_addr;
    mem_op_e               s1_op;
    byte_mask_t            s1_mask;
    logic [31:0]           s1_wdata;
    logic [31:0]           s2_word;
    byte_mask_t            mask_d;

    assign ready_o = !stall_i;

    // byte lanes of the strobe move to the addressed word of the line
    assign mask_d = byte_mask_t'(wstrb_i) << {addr_i[OFFSET_WIDTH-1:2], 2'b00};

    // arrays are read as the request moves into stage 2
    assign rd_en_o    = s1_valid && !stall_i;
    assign rd_index_o = s1_addr[OFFSET_WIDTH +: INDEX_WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            s2_valid_o <= 1'b0;
        end else if (!stall_i) begin
            s1_valid   <= valid_i;
            s2_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            s1_addr     <= addr_i;
            s1_op       <= (wstrb_i != 4'b0000) ? OP_STORE : OP_LOAD;
            s1_mask     <= mask_d;
            s1_wdata    <= wdata_i;

            s2_op_o     <= s1_op;
            s2_tag_o    <= s1_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
            s2_index_o  <= s1_addr[OFFSET_WIDTH +: INDEX_WIDTH];
            s2_offset_o <= s1_addr[OFFSET_WIDTH-1:0];
            s2_mask_o   <= s1_mask;
            s2_word     <= s1_wdata;
        end
    end

    // store word copied to every word slot, the mask picks the bytes
    assign s2_wdata_o = {WORDS_PER_LINE{s2_word}};

endmodule

//--- design/dcache_execute.sv
`timescale 1ns/1ps

module dcache_execute
    import dcache_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           s2_valid_i,
    input  mem_op_e                        s2_op_i,
    input  tag_t                           s2_tag_i,
    input  index_t                         s2_index_i,
    input  line_t                          s2_wdata_i,
    input  byte_mask_t                     s2_mask_i,
    input  logic [NWAY-1:0][TAG_WIDTH+1:0] tag_rdata_i,
    input  line_t [NWAY-1:0]               data_rdata_i,
    input  logic                           mem_wdone_i,
    input  logic                           mem_rvalid_i,
    input  line_t                          mem_rdata_i,
    output logic                           stall_o,
    output index_t                         wr_index_o,
    output logic [NWAY-1:0]                tag_we_o,
    output logic [TAG_WIDTH+1:0]           tag_wdata_o,
    output byte_mask_t [NWAY-1:0]          data_we_o,
    output line_t                          data_wdata_o,
    output logic                           mem_rreq_o,
    output logic [ADDR_WIDTH-1:0]          mem_raddr_o,
    output logic                           mem_wreq_o,
    output logic [ADDR_WIDTH-1:0]          mem_waddr_o,
    output line_t                          mem_wdata_o,
    output logic                           resp_o,
    output line_t                          resp_line_o
);

    miss_state_e           state_q;
    miss_state_e           state_d;
    logic [LFSR_WIDTH-1:0] lfsr_q;
    logic                  lfsr_fb;
    logic [WAY_WIDTH-1:0]  victim_sel;
    logic [WAY_WIDTH-1:0]  victim_q;
    logic                  victim_dirty;
    logic [NWAY-1:0]       way_hit;
    logic                  hit;
    logic                  miss;
    logic                  is_store;
    logic                  fill_done;
    line_t                 hit_line;
    line_t                 merged_line;

    always_comb begin
        way_hit  = '0;
        hit_line = '0;
        for (int w = 0; w < NWAY; w++) begin
            way_hit[w] = tag_rdata_i[w][TAG_WIDTH] &&
                         (tag_rdata_i[w][TAG_WIDTH-1:0] == s2_tag_i);
            if (way_hit[w]) begin
                hit_line = data_rdata_i[w];
            end
        end
    end

    assign hit       = s2_valid_i && (|way_hit);
    assign miss      = s2_valid_i && !(|way_hit);
    assign is_store  = (s2_op_i == OP_STORE);
    assign fill_done = (state_q == ST_FILL_WAIT) && mem_rvalid_i;

    // store bytes over the refill data
    // on a store hit only the masked bytes reach the RAM
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            merged_line[b*8 +: 8] = s2_mask_i[b] ? s2_wdata_i[b*8 +: 8] : mem_rdata_i[b*8 +: 8];
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    assign lfsr_fb = lfsr_q[LFSR_WIDTH-1] ^ lfsr_q[LFSR_WIDTH-3] ^
                     lfsr_q[LFSR_WIDTH-4] ^ lfsr_q[LFSR_WIDTH-6];

    assign victim_sel   = lfsr_q[WAY_WIDTH-1:0];
    assign victim_dirty = tag_rdata_i[victim_sel][TAG_WIDTH+1] &&
                          tag_rdata_i[victim_sel][TAG_WIDTH];

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = victim_dirty ? ST_WB_REQ : ST_FILL_REQ;
                end
            end
            ST_WB_REQ: begin
                state_d = ST_WB_WAIT;
            end
            ST_WB_WAIT: begin
                if (mem_wdone_i) begin
                    state_d = ST_FILL_REQ;
                end
            end
            ST_FILL_REQ: begin
                state_d = ST_FILL_WAIT;
            end
            ST_FILL_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            lfsr_q  <= LFSR_WIDTH'(1);
        end else begin
            state_q <= state_d;
            lfsr_q  <= {lfsr_q[LFSR_WIDTH-2:0], lfsr_fb};
        end
    end

    // victim way is fixed for the whole miss sequence
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && miss) begin
            victim_q <= victim_sel;
        end
    end

    always_comb begin
        tag_we_o  = '0;
        data_we_o = '0;
        if (state_q == ST_IDLE && hit && is_store) begin
            tag_we_o = way_hit;
            for (int w = 0; w < NWAY; w++) begin
                if (way_hit[w]) begin
                    data_we_o[w] = s2_mask_i;
                end
            end
        end else if (fill_done) begin
            tag_we_o[victim_q]  = 1'b1;
            data_we_o[victim_q] = '1;
        end
    end

    // dirty is set by a store hit and by a refill for a store
    assign wr_index_o   = s2_index_i;
    assign tag_wdata_o  = {is_store, 1'b1, s2_tag_i};
    assign data_wdata_o = merged_line;

    assign mem_wreq_o  = (state_q == ST_WB_REQ);
    assign mem_waddr_o = {tag_rdata_i[victim_q][TAG_WIDTH-1:0], s2_index_i,
                          {OFFSET_WIDTH{1'b0}}};
    assign mem_wdata_o = data_rdata_i[victim_q];
    assign mem_rreq_o  = (state_q == ST_FILL_REQ);
    assign mem_raddr_o = {s2_tag_i, s2_index_i, {OFFSET_WIDTH{1'b0}}};

    // the pipeline moves again in the cycle the refill returns
    assign stall_o     = (state_q == ST_IDLE) ? miss : !fill_done;
    assign resp_o      = (state_q == ST_IDLE) ? hit : fill_done;
    assign resp_line_o = fill_done ? merged_line : hit_line;

endmodule

//--- design/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int NWAY           = 2;
    localparam int NSET           = 64;
    localparam int LINE_BYTES     = 16;
    localparam int LINE_WIDTH     = LINE_BYTES * 8;
    localparam int WORDS_PER_LINE = LINE_WIDTH / 32;

    // address split: tag | index | offset
    localparam int OFFSET_WIDTH   = $clog2(LINE_BYTES);
    localparam int INDEX_WIDTH    = $clog2(NSET);
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    localparam int WAY_WIDTH      = $clog2(NWAY);
    localparam int LFSR_WIDTH     = 16;

    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [LINE_WIDTH-1:0]  line_t;
    typedef logic [LINE_BYTES-1:0]  byte_mask_t;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } mem_op_e;

    // miss handling: optional write-back of the victim, then refill
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB_REQ,
        ST_WB_WAIT,
        ST_FILL_REQ,
        ST_FILL_WAIT
    } miss_state_e;

endpackage

//--- design/dcache_result.sv
`timescale 1ns/1ps

module dcache_result
    import dcache_pkg::*;
(
    input  logic                    resp_i,
    input  line_t                   resp_line_i,
    input  logic [OFFSET_WIDTH-1:0] s2_offset_i,
    output logic                    data_ok_o,
    output logic [31:0]             rdata_o
);

    logic [$clog2(WORDS_PER_LINE)-1:0] word_sel;

    assign word_sel = s2_offset_i[OFFSET_WIDTH-1:2];

    assign data_ok_o = resp_i;

    // pick the addressed word out of the line
    always_comb begin
        rdata_o = resp_line_i[31:0];
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            if (word_sel == i) begin
                rdata_o = resp_line_i[i*32 +: 32];
            end
        end
    end

endmodule

//--- project.f
design/dcache_pkg.sv
design/dcache_decode.sv
design/dcache_arrays.sv
design/dcache_execute.sv
design/dcache_result.sv
design/dcache.sv
test/dcache_assertions.sv
test/dcache_tb.sv

//--- test/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions
    import dcache_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  valid_i,
    input logic [ADDR_WIDTH-1:0] addr_i,
    input logic [3:0]            wstrb_i,
    input logic [31:0]           wdata_i,
    input logic                  ready_i,
    input logic                  data_ok_i,
    input logic [31:0]           rdata_i,
    input logic                  mem_rreq_i,
    input logic [ADDR_WIDTH-1:0] mem_raddr_i,
    input logic                  mem_wreq_i,
    input logic [ADDR_WIDTH-1:0] mem_waddr_i,
    input line_t                 mem_wdata_i,
    input logic                  mem_rvalid_i,
    input logic                  mem_wdone_i
);

    int                    fail_count = 0;
    line_t                 shadow [256];
    logic [255:0]          written;
    logic [ADDR_WIDTH-1:0] q_addr [8];
    logic [3:0]            q_strb [8];
    logic [31:0]           q_data [8];
    logic [2:0]            wr_ptr;
    logic [2:0]            rd_ptr;
    logic [3:0]            pending;
    logic                  accept;
    logic                  pop;
    logic                  acc_q1;
    logic                  acc_q2;
    logic                  rst_q;
    logic                  mem_busy;
    logic [7:0]            head_idx;
    logic [ADDR_WIDTH-1:0] fill_addr;
    line_t                 head_line;
    line_t                 store_line;
    line_t                 wb_line;
    logic [31:0]           exp_word;

    // memory contents before any store are the address xor 5a in every byte
    function automatic line_t init_line(input logic [7:0] idx);
        line_t      l;
        logic [7:0] a;
        for (int b = 0; b < LINE_BYTES; b++) begin
            a = {idx[3:0], 4'(b)};
            l[b*8 +: 8] = a ^ 8'h5a;
        end
        return l;
    endfunction

    assign accept   = valid_i && ready_i;
    assign pop      = data_ok_i && (pending != 4'd0);
    assign head_idx = q_addr[rd_ptr][11:4];

    // the oldest outstanding request is the one that missed
    assign fill_addr = {q_addr[rd_ptr][ADDR_WIDTH-1:4], 4'b0000};

    always_comb begin
        head_line  = written[head_idx] ? shadow[head_idx] : init_line(head_idx);
        wb_line    = written[mem_waddr_i[11:4]] ? shadow[mem_waddr_i[11:4]]
                                                : init_line(mem_waddr_i[11:4]);
        exp_word   = head_line[q_addr[rd_ptr][3:2]*32 +: 32];
        store_line = head_line;
        for (int b = 0; b < 4; b++) begin
            if (q_strb[rd_ptr][b]) begin
                store_line[q_addr[rd_ptr][3:2]*32 + b*8 +: 8] = q_data[rd_ptr][b*8 +: 8];
            end
        end
    end

    // stores reach the shadow in order as they complete
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            pending  <= '0;
            written  <= '0;
            acc_q1   <= 1'b0;
            acc_q2   <= 1'b0;
            mem_busy <= 1'b0;
            rst_q    <= 1'b1;
        end else begin
            rst_q   <= 1'b0;
            acc_q1  <= accept;
            acc_q2  <= acc_q1;
            pending <= pending + 4'(accept) - 4'(pop);
            if (accept) begin
                q_addr[wr_ptr] <= addr_i;
                q_strb[wr_ptr] <= wstrb_i;
                q_data[wr_ptr] <= wdata_i;
                wr_ptr         <= wr_ptr + 3'd1;
            end
            if (pop) begin
                if (q_strb[rd_ptr] != 4'b0000) begin
                    shadow[head_idx]  <= store_line;
                    written[head_idx] <= 1'b1;
                end
                rd_ptr <= rd_ptr + 3'd1;
            end
            if (mem_rreq_i || mem_wreq_i) begin
                mem_busy <= 1'b1;
            end else if (mem_rvalid_i || mem_wdone_i) begin
                mem_busy <= 1'b0;
            end
        end
    end

    a_reset: assert property (@(posedge clk)
        rst_q && !rst |-> ready_i && !data_ok_i && !mem_rreq_i && !mem_wreq_i)
    else begin
        fail_count++;
        $error("outputs not in their idle state after reset");
    end

    a_order: assert property (@(posedge clk) disable iff (rst)
        data_ok_i |-> pending != 4'd0)
    else begin
        fail_count++;
        $error("data_ok_o pulse without an accepted request");
    end

    a_load: assert property (@(posedge clk) disable iff (rst)
        pop && q_strb[rd_ptr] == 4'b0000 |-> rdata_i == exp_word)
    else begin
        fail_count++;
        $error("error rdata_o %h expected %h", $sampled(rdata_i), $sampled(exp_word));
    end

    a_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_rreq_i && mem_wreq_i))
    else begin
        fail_count++;
        $error("read and write requests to memory in the same cycle");
    end

    a_one_op: assert property (@(posedge clk) disable iff (rst)
        mem_rreq_i || mem_wreq_i |-> !mem_busy)
    else begin
        fail_count++;
        $error("memory request while another one is outstanding");
    end

    a_fill: assert property (@(posedge clk) disable iff (rst)
        mem_rreq_i |-> mem_raddr_i == fill_addr)
    else begin
        fail_count++;
        $error("error mem_raddr_o %h expected %h", $sampled(mem_raddr_i),
               $sampled(fill_addr));
    end

    a_wb: assert property (@(posedge clk) disable iff (rst)
        mem_wreq_i |-> mem_waddr_i[3:0] == 4'd0 && mem_wdata_i == wb_line)
    else begin
        fail_count++;
        $error("error mem_waddr_o %h mem_wdata_o %h expected %h", $sampled(mem_waddr_i),
               $sampled(mem_wdata_i), $sampled(wb_line));
    end

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        acc_q2 && ready_i |-> data_ok_i)
    else begin
        fail_count++;
        $error("hit did not respond two edges after acceptance");
    end

endmodule

bind dcache dcache_assertions u_chk (
    .clk          (clk),
    .rst          (rst),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .wstrb_i      (wstrb_i),
    .wdata_i      (wdata_i),
    .ready_i      (ready_o),
    .data_ok_i    (data_ok_o),
    .rdata_i      (rdata_o),
    .mem_rreq_i   (mem_rreq_o),
    .mem_raddr_i  (mem_raddr_o),
    .mem_wreq_i   (mem_wreq_o),
    .mem_waddr_i  (mem_waddr_o),
    .mem_wdata_i  (mem_wdata_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_wdone_i  (mem_wdone_i)
);

//--- test/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
;

    localparam int TIMEOUT = 200;

    logic                  clk;
    logic                  rst;
    logic                  valid_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic [3:0]            wstrb_i;
    logic [31:0]           wdata_i;
    logic                  ready_o;
    logic                  data_ok_o;
    logic [31:0]           rdata_o;
    logic                  mem_rreq_o;
    logic [ADDR_WIDTH-1:0] mem_raddr_o;
    logic                  mem_wreq_o;
    logic [ADDR_WIDTH-1:0] mem_waddr_o;
    line_t                 mem_wdata_o;
    logic                  mem_rvalid_i;
    line_t                 mem_rdata_i;
    logic                  mem_wdone_i;

    logic [31:0] lcg_state = 32'hae1;
    logic [31:0] mem_lcg = 32'hae1;
    line_t       mem [256];
    int          timeouts = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          errors_at_start;
    logic [31:0] a;
    logic [31:0] r;

    dcache dut_i (.*);

    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state >> 16;
    endfunction

    // few tags over few sets so lines conflict and get evicted
    function automatic logic [31:0] rand_addr();
        logic [31:0] v;
        logic [31:0] x;
        v = next_rand(lcg_state);
        x = '0;
        x[11:10] = v[9:8];
        x[5:4]   = v[5:4];
        x[3:2]   = v[3:2];
        return x;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory model answering after 1 to 6 cycles
    initial begin
        logic [7:0]  idx;
        logic [31:0] d;
        for (int l = 0; l < 256; l++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                mem[l][b*8 +: 8] = {l[3:0], 4'(b)} ^ 8'h5a;
            end
        end
        forever begin
            if (mem_wreq_o === 1'b1) begin
                idx = mem_waddr_o[11:4];
                mem[idx] = mem_wdata_o;
                d = next_rand(mem_lcg);
                repeat (1 + int'(d % 6)) @(negedge clk);
                mem_wdone_i = 1'b1;
                @(negedge clk);
                mem_wdone_i = 1'b0;
            end else if (mem_rreq_o === 1'b1) begin
                idx = mem_raddr_o[11:4];
                d = next_rand(mem_lcg);
                repeat (1 + int'(d % 6)) @(negedge clk);
                mem_rdata_i  = mem[idx];
                mem_rvalid_i = 1'b1;
                @(negedge clk);
                mem_rvalid_i = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    task automatic issue(input logic [31:0] addr, input logic [3:0] strb,
                         input logic [31:0] data);
        int cnt;
        cnt = 0;
        valid_i = 1'b1;
        addr_i  = addr;
        wstrb_i = strb;
        wdata_i = data;
        @(posedge clk);
        while (!ready_o && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("timeout: request to address %h was never accepted", addr);
            timeouts++;
        end
        @(negedge clk);
    endtask

    // aligned store of a random size into the word at addr
    task automatic rand_store(input logic [31:0] addr);
        logic [31:0] v;
        logic [31:0] d;
        logic [3:0]  strb;
        logic [1:0]  off;
        v = next_rand(lcg_state);
        d = {next_rand(lcg_state) << 16} | next_rand(lcg_state);
        case (v[2:0])
            3'd0: begin
                strb = 4'b0001;
                off  = 2'd0;
            end
            3'd1: begin
                strb = 4'b0010;
                off  = 2'd1;
            end
            3'd2: begin
                strb = 4'b0100;
                off  = 2'd2;
            end
            3'd3: begin
                strb = 4'b1000;
                off  = 2'd3;
            end
            3'd4: begin
                strb = 4'b0011;
                off  = 2'd0;
            end
            3'd5: begin
                strb = 4'b1100;
                off  = 2'd2;
            end
            default: begin
                strb = 4'b1111;
                off  = 2'd0;
            end
        endcase
        issue({addr[31:2], off}, strb, d);
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        valid_i = 1'b0;
        wstrb_i = 4'b0000;
        while (dut_i.u_chk.pending != 4'd0 && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("timeout: responses still outstanding after the last request");
            timeouts++;
        end
    endtask

    task automatic start_test();
        errors_at_start = dut_i.u_chk.fail_count + timeouts;
    endtask

    task automatic end_test(input string name);
        int n;
        n = dut_i.u_chk.fail_count + timeouts - errors_at_start;
        tests++;
        if (n != 0) begin
            failed_tests++;
        end
        $display("test %s: %s (%0d errors)", name, (n == 0) ? "pass" : "fail", n);
    endtask

    initial begin
        rst          = 1'b1;
        valid_i      = 1'b0;
        addr_i       = '0;
        wstrb_i      = 4'b0000;
        wdata_i      = '0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_wdone_i  = 1'b0;

        start_test();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        end_test("reset");

        // back-to-back loads to the same line
        start_test();
        repeat (40) begin
            a = rand_addr();
            issue(a, 4'b0000, '0);
            issue(a, 4'b0000, '0);
            issue(a ^ 32'd4, 4'b0000, '0);
        end
        drain();
        end_test("loads");

        start_test();
        repeat (40) begin
            a = rand_addr();
            rand_store(a);
            issue(a, 4'b0000, '0);
        end
        drain();
        end_test("stores");

        // every tag into one set so dirty victims get written back
        start_test();
        for (int round = 0; round < 4; round++) begin
            for (int t = 0; t < 4; t++) begin
                a = (32'(t) << 10) | (32'd1 << 4) | (32'(round) << 2);
                rand_store(a);
                issue(a, 4'b0000, '0);
            end
        end
        drain();
        end_test("evictions");

        start_test();
        repeat (300) begin
            r = next_rand(lcg_state);
            a = rand_addr();
            if (r[0]) begin
                issue(a, 4'b0000, '0);
            end else begin
                rand_store(a);
            end
        end
        drain();
        end_test("mixed");

        $display("%0d tests, %0d failed, %0d assertion failures, %0d timeouts",
                 tests, failed_tests, dut_i.u_chk.fail_count, timeouts);
        if (failed_tests == 0 && dut_i.u_chk.fail_count == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
